// ==== dv/wb_input.txt ====
// pc0 pc1 inst0 inst1 src_a0 src_b0 src_a1 src_b1 csr_rdata irq cache_wait cache_word
// expected: we0 rd0 data0 we1 rd1 data1 ecode(3f none) badv, all hex
100 104 20000001 40000002 5 3 a 3 0 0 0 0 1 1 8 1 2 7 3f 0
108 10c 60000003 80000004 f0f0 ff00 f0 f 0 0 0 0 1 3 f000 1 4 ff 3f 0
110 114 20000000 40000005 1 1 1 3 0 0 0 0 0 0 0 1 5 fffffffe 3f 0
118 11c a0000006 20000007 1000 20 2 2 0 0 0 cafe0001 1 6 cafe0001 1 7 4 3f 0
120 124 a0000008 80000009 2000 4 1 2 0 0 3 12345678 1 8 12345678 1 9 3 3f 0
128 12c c000000a a000000b 0 0 5 5 beef 0 0 0 1 a beef 0 0 0 3f 0
130 134 a000000c 2000000d 1000 2 1 1 0 0 0 0 0 0 0 0 0 0 9 1002
138 13c 2000000e 2000000f 1 2 3 4 0 0 0 0 0 0 0 0 0 0 3f 0
140 144 40000010 60000011 9 4 c a 0 0 0 0 1 10 5 1 11 8 3f 0
148 14c e0000000 20000012 0 0 1 1 0 0 0 0 0 0 0 0 0 0 b 0
150 154 a0000013 0 3000 0 0 0 0 0 2 5555 0 0 0 0 0 0 3f 0
158 15c 20000014 80000015 7 8 30 3 0 1 0 0 1 14 f 1 15 33 0 0
160 164 20000016 20000017 1 1 1 1 0 0 0 0 0 0 0 0 0 0 3f 0
168 16c 20000018 40000019 ffffffff 1 0 1 0 0 0 0 1 18 0 1 19 ffffffff 3f 0

// ==== verilog.f ====
common/wb_pkg.sv
common/pipe_if.sv
hdl/uop_decode.sv
hdl/lane_execute.sv
writeback/wb_commit.sv
writeback/exc_commit.sv
hdl/ex2_wb_top.sv
dv/tb_ex2_wb.sv

// ==== Bender.yml ====
package:
  name: ex2_wb

sources:
  - common/wb_pkg.sv
  - common/pipe_if.sv
  - hdl/uop_decode.sv
  - hdl/lane_execute.sv
  - writeback/wb_commit.sv
  - writeback/exc_commit.sv
  - hdl/ex2_wb_top.sv
  - target: test
    files:
      - dv/tb_ex2_wb.sv

// ==== dv/tb_ex2_wb.sv ====
`timescale 1ns/1ps

module tb_ex2_wb;

    // words per vector line
    localparam int NF      = 20;
    localparam int MAX_VEC = 32;
    // exception entry handed to the core
    localparam logic [31:0] EENTRY = 32'h1c00_8000;

    logic        clk = 1'b0;
    logic        aresetn;
    logic        issue_valid;
    logic        issue_ready;
    logic [31:0] pc0;
    logic [31:0] pc1;
    logic [31:0] inst0;
    logic [31:0] inst1;
    logic [31:0] src_a0;
    logic [31:0] src_b0;
    logic [31:0] src_a1;
    logic [31:0] src_b1;
    logic        dcache_req;
    logic [31:0] dcache_addr;
    logic        dcache_ready;
    logic [31:0] dcache_data;
    logic [31:0] csr_rdata;
    logic [31:0] eentry;
    logic        cpu_interrupt;
    logic        wb_we0;
    logic [4:0]  wb_rd0;
    logic [31:0] wb_data0;
    logic        wb_we1;
    logic [4:0]  wb_rd1;
    logic [31:0] wb_data1;
    logic        exception_flag;
    logic [5:0]  ecode_out;
    logic [31:0] badv_out;
    logic        wen_badv;
    logic [31:0] era_out;
    logic        wen_era;
    logic [31:0] redirect_pc;
    logic [31:0] debug0_pc;
    logic [31:0] debug1_pc;
    logic        debug_valid;

    // vector table, NF words per vector
    logic [31:0] vmem [0:NF*MAX_VEC-1];
    logic [31:0] fld [0:NF-1];
    int          nvec = 0;
    int          max_wait = 0;
    int          limit = 0;
    int          cycles = 0;
    int          errors = 0;
    int          tests = 0;
    logic        test_bad = 1'b0;
    // last retired pair raised an exception
    logic        prev_exc = 1'b0;
    // vector on the issue inputs, in ex, on the write-back outputs
    int          drv_idx;
    int          ex_idx;
    int          wb_idx;
    // cache wait cycles spent on the load in ex
    int          wait_cnt;

    ex2_wb_top i_ex2_wb_top (.*);

    always #5 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: pipe still busy after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] vec_field(input int idx, input int f);
        return vmem[idx * NF + f];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        errors++;
        test_bad = 1'b1;
    endtask

    // idx below zero leaves the issue port idle
    task automatic drive_issue(input int idx);
        issue_valid = 1'b0;
        pc0         = 32'h0;
        pc1         = 32'h0;
        inst0       = 32'h0;
        inst1       = 32'h0;
        src_a0      = 32'h0;
        src_b0      = 32'h0;
        src_a1      = 32'h0;
        src_b1      = 32'h0;
        if (idx >= 0 && idx < nvec) begin
            issue_valid = 1'b1;
            pc0         = vec_field(idx, 0);
            pc1         = vec_field(idx, 1);
            inst0       = vec_field(idx, 2);
            inst1       = vec_field(idx, 3);
            src_a0      = vec_field(idx, 4);
            src_b0      = vec_field(idx, 5);
            src_a1      = vec_field(idx, 6);
            src_b1      = vec_field(idx, 7);
        end
    endtask

    // csr value, interrupt line and cache model for the pair in ex
    task automatic drive_ex_inputs(input int idx);
        logic [31:0] exp_addr;
        csr_rdata     = 32'h0;
        cpu_interrupt = 1'b0;
        dcache_ready  = 1'b0;
        dcache_data   = 32'h0;
        if (idx >= 0) begin
            csr_rdata     = vec_field(idx, 8);
            cpu_interrupt = vec_field(idx, 9) != 0;
            // ready after the listed number of wait cycles
            if (dcache_req) begin
                // load address is base plus offset
                exp_addr = vec_field(idx, 4) + vec_field(idx, 5);
                if (dcache_addr !== exp_addr)
                    report_mismatch("dcache_addr", dcache_addr, exp_addr);
                if (wait_cnt == vec_field(idx, 10)) begin
                    dcache_ready = 1'b1;
                    dcache_data  = vec_field(idx, 11);
                end else begin
                    wait_cnt++;
                end
            end
        end
    endtask

    // outputs now show the pair that left ex at the last edge
    task automatic check_retired(input int idx);
        logic        exp_exc;
        logic [31:0] code;
        code    = vec_field(idx, 18);
        // code 3f marks no exception
        exp_exc = (code != 32'h3f);
        if (wb_we0 !== vec_field(idx, 12))
            report_mismatch("wb_we0", wb_we0, vec_field(idx, 12));
        if (vec_field(idx, 12) != 0 && wb_rd0 !== vec_field(idx, 13))
            report_mismatch("wb_rd0", wb_rd0, vec_field(idx, 13));
        if (vec_field(idx, 12) != 0 && wb_data0 !== vec_field(idx, 14))
            report_mismatch("wb_data0", wb_data0, vec_field(idx, 14));
        if (wb_we1 !== vec_field(idx, 15))
            report_mismatch("wb_we1", wb_we1, vec_field(idx, 15));
        if (vec_field(idx, 15) != 0 && wb_rd1 !== vec_field(idx, 16))
            report_mismatch("wb_rd1", wb_rd1, vec_field(idx, 16));
        if (vec_field(idx, 15) != 0 && wb_data1 !== vec_field(idx, 17))
            report_mismatch("wb_data1", wb_data1, vec_field(idx, 17));
        if (exception_flag !== exp_exc)
            report_mismatch("exception_flag", exception_flag, exp_exc);
        if (wen_era !== exp_exc)
            report_mismatch("wen_era", wen_era, exp_exc);
        // badv is written for misaligned loads only
        if (wen_badv !== (code == 32'h9))
            report_mismatch("wen_badv", wen_badv, code == 32'h9);
        if (exp_exc && ecode_out !== code)
            report_mismatch("ecode_out", ecode_out, code);
        if (exp_exc && era_out !== vec_field(idx, 0))
            report_mismatch("era_out", era_out, vec_field(idx, 0));
        if (exp_exc && redirect_pc !== EENTRY)
            report_mismatch("redirect_pc", redirect_pc, EENTRY);
        if (code == 32'h9 && badv_out !== vec_field(idx, 19))
            report_mismatch("badv_out", badv_out, vec_field(idx, 19));
        // the pair behind an exception leaves an empty trace
        if (debug_valid !== !prev_exc)
            report_mismatch("debug_valid", debug_valid, !prev_exc);
        if (debug0_pc !== (prev_exc ? 32'h0 : vec_field(idx, 0)))
            report_mismatch("debug0_pc", debug0_pc, prev_exc ? 32'h0 : vec_field(idx, 0));
        if (debug1_pc !== (prev_exc ? 32'h0 : vec_field(idx, 1)))
            report_mismatch("debug1_pc", debug1_pc, prev_exc ? 32'h0 : vec_field(idx, 1));
        prev_exc = exp_exc;
        tests++;
        $display("test %0d pc %h: %s", idx + 1, vec_field(idx, 0), test_bad ? "fail" : "ok");
        test_bad = 1'b0;
    endtask

    initial begin
        int    fd;
        int    code;
        int    f;
        string line;
        logic  go;
        logic  take_in;
        fd = $fopen("dv/wb_input.txt", "r");
        while (fd != 0 && !$feof(fd) && nvec < MAX_VEC) begin
            code = $fgets(line, fd);
            // comment lines do not scan
            if (code != 0 && $sscanf(line,
                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                fld[15], fld[16], fld[17], fld[18], fld[19]) == NF) begin
                for (f = 0; f < NF; f++) begin
                    vmem[nvec * NF + f] = fld[f];
                end
                if (fld[10] > max_wait)
                    max_wait = fld[10];
                nvec++;
            end
        end
        if (fd != 0)
            $fclose(fd);
        if (nvec == 0) begin
            $display("no test vectors could be read from dv/wb_input.txt");
            errors++;
        end
        limit = nvec * (4 + max_wait) + 20;

        // quiet inputs through reset
        aresetn  = 1'b0;
        eentry   = EENTRY;
        wait_cnt = 0;
        drv_idx  = 0;
        ex_idx   = -1;
        wb_idx   = -1;
        go       = 1'b0;
        take_in  = 1'b0;
        drive_issue(-1);
        drive_ex_inputs(-1);
        repeat (2) @(posedge clk);
        @(negedge clk);
        aresetn = 1'b1;

        do begin
            // a pair moves on only at an edge with issue_ready high
            if (go) begin
                wb_idx = ex_idx;
                ex_idx = take_in ? drv_idx : -1;
                if (take_in)
                    drv_idx++;
                wait_cnt = 0;
            end else begin
                wb_idx = -1;
            end
            if (wb_idx >= 0) begin
                check_retired(wb_idx);
            end else begin
                if (wb_we0 || wb_we1 || exception_flag) begin
                    $display("write-back or exception at %0t with no pair retiring", $time);
                    errors++;
                end
                prev_exc = 1'b0;
            end
            drive_issue(drv_idx);
            drive_ex_inputs(ex_idx);
            // sample the settled ready level, well before the next edge
            #1;
            if (dcache_req && !dcache_ready && issue_ready)
                report_mismatch("issue_ready", issue_ready, 1'b0);
            go      = issue_ready;
            take_in = issue_valid && issue_ready;
            @(negedge clk);
        end while (drv_idx < nvec || ex_idx >= 0 || wb_idx >= 0);

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== hdl/ex2_wb_top.sv ====
`timescale 1ns/1ps

module ex2_wb_top import wb_pkg::*; #(
    parameter int DATA_W = DATA_W_DEF
) (
    input  logic              clk,
    input  logic              aresetn,
    // issue side
    input  logic              issue_valid,
    output logic              issue_ready,
    input  logic [DATA_W-1:0] pc0,
    input  logic [DATA_W-1:0] pc1,
    input  logic [31:0]       inst0,
    input  logic [31:0]       inst1,
    input  logic [DATA_W-1:0] src_a0,
    input  logic [DATA_W-1:0] src_b0,
    input  logic [DATA_W-1:0] src_a1,
    input  logic [DATA_W-1:0] src_b1,
    // data cache
    output logic              dcache_req,
    output logic [DATA_W-1:0] dcache_addr,
    input  logic              dcache_ready,
    input  logic [DATA_W-1:0] dcache_data,
    // csr file and interrupt
    input  logic [DATA_W-1:0] csr_rdata,
    input  logic [DATA_W-1:0] eentry,
    input  logic              cpu_interrupt,
    // register file write ports
    output logic              wb_we0,
    output logic [RD_W-1:0]   wb_rd0,
    output logic [DATA_W-1:0] wb_data0,
    output logic              wb_we1,
    output logic [RD_W-1:0]   wb_rd1,
    output logic [DATA_W-1:0] wb_data1,
    // exception state to the csr file
    output logic              exception_flag,
    output ecode_e            ecode_out,
    output logic [DATA_W-1:0] badv_out,
    output logic              wen_badv,
    output logic [DATA_W-1:0] era_out,
    output logic              wen_era,
    output logic [DATA_W-1:0] redirect_pc,
    // trace
    output logic [DATA_W-1:0] debug0_pc,
    output logic [DATA_W-1:0] debug1_pc,
    output logic              debug_valid
);

    logic allowin;

    issue_if  #(.DATA_W(DATA_W)) ex0_if ();
    issue_if  #(.DATA_W(DATA_W)) ex1_if ();
    result_if #(.DATA_W(DATA_W)) res0_if ();
    result_if #(.DATA_W(DATA_W)) res1_if ();

    // one stall level for the whole back end
    assign issue_ready = allowin;

    uop_decode #(.DATA_W(DATA_W)) i_uop_decode (
        .clk         (clk),
        .aresetn     (aresetn),
        .issue_valid (issue_valid),
        .pc0         (pc0),
        .pc1         (pc1),
        .inst0       (inst0),
        .inst1       (inst1),
        .src_a0      (src_a0),
        .src_b0      (src_b0),
        .src_a1      (src_a1),
        .src_b1      (src_b1),
        .allowin     (allowin),
        .flush       (exception_flag),
        .ex0         (ex0_if.producer),
        .ex1         (ex1_if.producer)
    );

    lane_execute #(.DATA_W(DATA_W)) i_lane_execute (
        .ex0         (ex0_if.consumer),
        .ex1         (ex1_if.consumer),
        .csr_rdata   (csr_rdata),
        .dcache_req  (dcache_req),
        .dcache_addr (dcache_addr),
        .res0        (res0_if.producer),
        .res1        (res1_if.producer)
    );

    wb_commit #(.DATA_W(DATA_W)) i_wb_commit (
        .clk            (clk),
        .aresetn        (aresetn),
        .res0           (res0_if.consumer),
        .res1           (res1_if.consumer),
        .dcache_ready   (dcache_ready),
        .dcache_data    (dcache_data),
        .exception_flag (exception_flag),
        .allowin        (allowin),
        .wb_we0         (wb_we0),
        .wb_rd0         (wb_rd0),
        .wb_data0       (wb_data0),
        .wb_we1         (wb_we1),
        .wb_rd1         (wb_rd1),
        .wb_data1       (wb_data1),
        .debug0_pc      (debug0_pc),
        .debug1_pc      (debug1_pc),
        .debug_valid    (debug_valid)
    );

    exc_commit #(.DATA_W(DATA_W)) i_exc_commit (
        .clk            (clk),
        .aresetn        (aresetn),
        .cpu_interrupt  (cpu_interrupt),
        .eentry         (eentry),
        .res0           (res0_if.consumer),
        .allowin        (allowin),
        .exception_flag (exception_flag),
        .ecode_out      (ecode_out),
        .badv_out       (badv_out),
        .wen_badv       (wen_badv),
        .era_out        (era_out),
        .wen_era        (wen_era),
        .redirect_pc    (redirect_pc)
    );

endmodule

// ==== writeback/exc_commit.sv ====
`timescale 1ns/1ps

module exc_commit import wb_pkg::*; #(
    parameter int DATA_W = DATA_W_DEF
) (
    input  logic              clk,
    input  logic              aresetn,
    input  logic              cpu_interrupt,
    input  logic [DATA_W-1:0] eentry,
    result_if.consumer        res0,
    input  logic              allowin,
    output logic              exception_flag,
    output ecode_e            ecode_out,
    output logic [DATA_W-1:0] badv_out,
    output logic              wen_badv,
    output logic [DATA_W-1:0] era_out,
    output logic              wen_era,
    output logic [DATA_W-1:0] redirect_pc
);

    logic   take;
    ecode_e code;

    // interrupts attach to a lane 0 instruction as it completes
    // nothing is taken while the flag from the last one is up
    assign take = res0.valid && allowin && !exception_flag
                  && (cpu_interrupt || res0.exc != EXC_NONE);

    // interrupt beats a synchronous fault
    assign code = cpu_interrupt ? EXC_INT : res0.exc;

    // one-cycle pulse with its enables
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            exception_flag <= 1'b0;
            wen_era        <= 1'b0;
            wen_badv       <= 1'b0;
        end else begin
            exception_flag <= take;
            wen_era        <= take;
            wen_badv       <= take && (code == EXC_ALE);
        end
    end

    // lane 0 data holds the load address
    always_ff @(posedge clk) begin
        if (take) begin
            ecode_out   <= code;
            badv_out    <= res0.data;
            era_out     <= res0.pc;
            redirect_pc <= eentry;
        end
    end

    // badv only ever carries a misaligned load address
    a_badv_with_flag: assert property (@(posedge clk) disable iff (!aresetn)
        wen_badv |-> (exception_flag && (badv_out[1:0] != 2'b00)))
        else $error("badv write without exception");

endmodule

// ==== writeback/wb_commit.sv ====
`timescale 1ns/1ps

module wb_commit import wb_pkg::*; #(
    parameter int DATA_W = DATA_W_DEF
) (
    input  logic              clk,
    input  logic              aresetn,
    result_if.consumer        res0,
    result_if.consumer        res1,
    input  logic              dcache_ready,
    input  logic [DATA_W-1:0] dcache_data,
    input  logic              exception_flag,
    output logic              allowin,
    output logic              wb_we0,
    output logic [RD_W-1:0]   wb_rd0,
    output logic [DATA_W-1:0] wb_data0,
    output logic              wb_we1,
    output logic [RD_W-1:0]   wb_rd1,
    output logic [DATA_W-1:0] wb_data1,
    output logic [DATA_W-1:0] debug0_pc,
    output logic [DATA_W-1:0] debug1_pc,
    output logic              debug_valid
);

    logic ld_wait;

    // live load that issued a cache request and has no data yet
    // faulting loads never reach the cache
    assign ld_wait = res0.valid && res0.is_mem && (res0.exc == EXC_NONE) && !dcache_ready;

    // whole pipe holds behind the load
    assign allowin = !ld_wait;

    // write enables and debug trace
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            wb_we0      <= 1'b0;
            wb_we1      <= 1'b0;
            debug0_pc   <= '0;
            debug1_pc   <= '0;
            debug_valid <= 1'b0;
        end else if (exception_flag) begin
            // pair behind the exception never commits
            wb_we0      <= 1'b0;
            wb_we1      <= 1'b0;
            debug0_pc   <= '0;
            debug1_pc   <= '0;
            debug_valid <= 1'b0;
        end else if (ld_wait) begin
            // both lanes retire together with the load
            wb_we0      <= 1'b0;
            wb_we1      <= 1'b0;
            debug_valid <= 1'b0;
        end else begin
            // we already carries valid and the fault kill
            wb_we0      <= res0.we;
            wb_we1      <= res1.we;
            debug0_pc   <= res0.pc;
            debug1_pc   <= res1.pc;
            debug_valid <= res0.valid;
        end
    end

    // lane 0 data source
    // execute result first, then the cache word
    always_ff @(posedge clk) begin
        if (!res0.is_mem) begin
            wb_data0 <= res0.data;
        end else if (dcache_ready) begin
            wb_data0 <= dcache_data;
        end
        wb_rd0 <= res0.rd;
    end

    // lane 1 is alu only
    always_ff @(posedge clk) begin
        wb_data1 <= res1.data;
        wb_rd1   <= res1.rd;
    end

    // decode drops the write for rd zero
    a_no_r0_write: assert property (@(posedge clk) disable iff (!aresetn)
        wb_we0 |-> (wb_rd0 != '0))
        else $error("lane 0 write to register zero");

endmodule

// ==== hdl/lane_execute.sv ====
`timescale 1ns/1ps

module lane_execute import wb_pkg::*; #(
    parameter int DATA_W = DATA_W_DEF
) (
    issue_if.consumer         ex0,
    issue_if.consumer         ex1,
    input  logic [DATA_W-1:0] csr_rdata,
    output logic              dcache_req,
    output logic [DATA_W-1:0] dcache_addr,
    result_if.producer        res0,
    result_if.producer        res1
);

    logic [DATA_W-1:0] alu0;
    logic [DATA_W-1:0] alu1;
    logic              misaligned0;
    ecode_e            exc0;

    // shared by both lanes
    // loads use the adder for their address
    function automatic logic [DATA_W-1:0] alu(input opcode_e op,
                                              input logic [DATA_W-1:0] a,
                                              input logic [DATA_W-1:0] b);
        case (op)
            OP_ADD, OP_LD: alu = a + b;
            OP_SUB:        alu = a - b;
            OP_AND:        alu = a & b;
            OP_OR:         alu = a | b;
            default:       alu = '0;
        endcase
    endfunction

    assign alu0 = alu(ex0.uop.op, ex0.src_a, ex0.src_b);
    assign alu1 = alu(ex1.uop.op, ex1.src_a, ex1.src_b);

    // word loads need a 4-byte aligned address
    assign misaligned0 = ex0.uop.is_mem && (alu0[1:0] != 2'b00);

    always_comb begin
        exc0 = EXC_NONE;
        if (ex0.valid && ex0.uop.op == OP_SYSCALL) begin
            exc0 = EXC_SYS;
        end else if (ex0.valid && misaligned0) begin
            exc0 = EXC_ALE;
        end
    end

    // no cache access for a faulting load
    assign dcache_req  = ex0.valid && ex0.uop.is_mem && !misaligned0;
    assign dcache_addr = alu0;

    // lane 0, csr value bypasses the alu
    assign res0.valid  = ex0.valid;
    assign res0.we     = ex0.valid && ex0.uop.writes_rd && (exc0 == EXC_NONE);
    assign res0.rd     = ex0.uop.rd;
    assign res0.data   = ex0.uop.is_csr ? csr_rdata : alu0;
    assign res0.pc     = ex0.pc;
    assign res0.is_mem = ex0.uop.is_mem;
    assign res0.exc    = exc0;

    // lane 1 is younger, a lane 0 fault cancels its write
    assign res1.valid  = ex1.valid;
    assign res1.we     = ex1.valid && ex1.uop.writes_rd && (exc0 == EXC_NONE);
    assign res1.rd     = ex1.uop.rd;
    assign res1.data   = alu1;
    assign res1.pc     = ex1.pc;
    assign res1.is_mem = 1'b0;
    assign res1.exc    = EXC_NONE;

endmodule

// ==== hdl/uop_decode.sv ====
`timescale 1ns/1ps

module uop_decode import wb_pkg::*; #(
    parameter int DATA_W = DATA_W_DEF
) (
    input  logic              clk,
    input  logic              aresetn,
    input  logic              issue_valid,
    input  logic [DATA_W-1:0] pc0,
    input  logic [DATA_W-1:0] pc1,
    input  logic [31:0]       inst0,
    input  logic [31:0]       inst1,
    input  logic [DATA_W-1:0] src_a0,
    input  logic [DATA_W-1:0] src_b0,
    input  logic [DATA_W-1:0] src_a1,
    input  logic [DATA_W-1:0] src_b1,
    input  logic              allowin,
    input  logic              flush,
    issue_if.producer         ex0,
    issue_if.producer         ex1
);

    logic v0_q;
    logic v1_q;

    // instruction word to micro-op
    // lane 1 has only an alu, anything else there turns into a nop
    function automatic uop_t decode(input logic [31:0] inst, input logic alu_only);
        uop_t u;
        u.op = opcode_e'(inst[31:29]);
        if (alu_only && !(u.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR})) begin
            u.op = OP_NOP;
        end
        u.rd        = inst[RD_W-1:0];
        u.writes_rd = (u.op != OP_NOP) && (u.op != OP_SYSCALL) && (u.rd != '0);
        u.is_mem    = (u.op == OP_LD);
        u.is_csr    = (u.op == OP_CSRRD);
        return u;
    endfunction

    // slot valids, held while commit stalls
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            v0_q <= 1'b0;
            v1_q <= 1'b0;
        end else if (allowin) begin
            v0_q <= issue_valid;
            v1_q <= issue_valid;
        end
    end

    // ex stage payload
    always_ff @(posedge clk) begin
        if (allowin) begin
            ex0.pc    <= pc0;
            ex0.uop   <= decode(inst0, 1'b0);
            ex0.src_a <= src_a0;
            ex0.src_b <= src_b0;
            ex1.pc    <= pc1;
            ex1.uop   <= decode(inst1, 1'b1);
            ex1.src_a <= src_a1;
            ex1.src_b <= src_b1;
        end
    end

    // the pair behind an exception is dead while the flag is up
    assign ex0.valid = v0_q && !flush;
    assign ex1.valid = v1_q && !flush;

    // stalled slot keeps its contents until commit lets it go
    a_hold_on_stall: assert property (@(posedge clk) disable iff (!aresetn)
        (!allowin && !flush) |=> ($stable(ex0.valid) && $stable(ex1.valid)))
        else $error("ex stage valid changed during stall");

endmodule

// ==== common/pipe_if.sv ====
`timescale 1ns/1ps

// one issue slot in the ex stage
interface issue_if import wb_pkg::*; #(parameter int DATA_W = DATA_W_DEF);
    logic              valid;
    logic [DATA_W-1:0] pc;
    uop_t              uop;
    logic [DATA_W-1:0] src_a;
    logic [DATA_W-1:0] src_b;

    modport producer (output valid, pc, uop, src_a, src_b);
    modport consumer (input valid, pc, uop, src_a, src_b);
endinterface

// one lane's execute outcome
interface result_if import wb_pkg::*; #(parameter int DATA_W = DATA_W_DEF);
    logic              valid;
    logic              we;
    logic [RD_W-1:0]   rd;
    // alu or csr value, load address for loads
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] pc;
    // lane 0 only, lane 1 ties these off
    logic              is_mem;
    ecode_e            exc;

    modport producer (output valid, we, rd, data, pc, is_mem, exc);
    modport consumer (input valid, we, rd, data, pc, is_mem, exc);
endinterface

// ==== common/wb_pkg.sv ====
package wb_pkg;

    // default datapath and address width
    localparam int DATA_W_DEF = 32;

    // register number width
    localparam int RD_W = 5;

    // major opcode, instruction bits 31..29
    typedef enum logic [2:0] {
        OP_NOP     = 3'd0,
        OP_ADD     = 3'd1,
        OP_SUB     = 3'd2,
        OP_AND     = 3'd3,
        OP_OR      = 3'd4,
        OP_LD      = 3'd5,
        OP_CSRRD   = 3'd6,
        OP_SYSCALL = 3'd7
    } opcode_e;

    // exception codes as seen by the csr file
    // none uses a code that no real exception takes
    typedef enum logic [5:0] {
        EXC_INT  = 6'h00,
        EXC_ALE  = 6'h09,
        EXC_SYS  = 6'h0b,
        EXC_NONE = 6'h3f
    } ecode_e;

    // decoded micro-op carried down the pipe
    typedef struct packed {
        // operation
        opcode_e         op;
        // destination register, inst[4:0]
        logic [RD_W-1:0] rd;
        // register file write, never for rd zero
        logic            writes_rd;
        // word load
        logic            is_mem;
        // csr read
        logic            is_csr;
    } uop_t;

    // empty slot
    localparam uop_t UOP_NOP = '{
        op:        OP_NOP,
        rd:        '0,
        writes_rd: 1'b0,
        is_mem:    1'b0,
        is_csr:    1'b0
    };

endpackage
